// ==== code_matcher.sv ====
`timescale 1ns/100ps

`include "lock_defs.svh"

module code_matcher
    import keypad_pkg::*;
    import door_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  logic          start,
    input  code_t         entered,
    input  code_slots_t   user_codes,
    output match_result_t result
);

    logic       busy;
    logic [1:0] idx;       // Slot under comparison
    code_t      code_q;    // Entered code held for the whole check
    code_t      slot_code;
    logic       slot_blank;
    logic       hit;
    logic       last;

    // Pick one user slot by index
    function automatic code_t slot_sel(input code_slots_t slots, input logic [1:0] sel);
        code_t c;
        case (sel)
            2'd0:    c = slots.slot0;
            2'd1:    c = slots.slot1;
            2'd2:    c = slots.slot2;
            default: c = slots.slot3;
        endcase
        return c;
    endfunction

    assign slot_code  = slot_sel(user_codes, idx);
    assign slot_blank = (slot_code == {4{`LOCK_DIGIT_BLANK}}); // Unused slot
    assign hit        = busy && !slot_blank && (slot_code == code_q);
    assign last       = (idx == 2'd3);

    assign result.done = busy && (hit || last);
    assign result.ok   = hit;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy <= 1'b0;
            idx  <= 2'd0;
        end else if (start) begin
            busy <= 1'b1;
            idx  <= 2'd0;
        end else if (busy) begin
            if (hit || last) begin
                busy <= 1'b0; // Stop at first match or after slot 3
            end else begin
                idx <= idx + 2'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            code_q <= entered;
        end
    end

    // The FSM must wait for done before it starts another check
    a_no_start_when_busy: assert property (
        @(posedge clk) disable iff (rst) start |-> !busy
    );

endmodule

// ==== door_fsm.sv ====
`timescale 1ns/100ps

`include "lock_defs.svh"

module door_fsm
    import keypad_pkg::*;
    import door_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  key_entry_t    entry,
    input  logic          door_open,
    input  logic          inside_button,
    input  match_result_t result,
    output logic          start,
    output code_t         entered,
    output lock_out_t     lock_out,
    output logic [2:0]    fail_count,
    output logic          lockout
);

    // Shared timer sized for the longest interval
    localparam int TIMER_W = $clog2(`LOCK_LOCKOUT_CYCLES + 1);

    door_state_t        state;
    logic [TIMER_W-1:0] timer;
    logic               timeout_digit;

    assign timeout_digit = (entry.code[3] == `LOCK_DIGIT_TIMEOUT);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= INIT;
            timer      <= '0;
            fail_count <= 3'd0;
            start      <= 1'b0;
        end else begin
            start <= 1'b0; // Single-cycle pulse
            case (state)
                INIT: begin
                    if (!door_open) state <= LOCKED;
                end
                LOCKED: begin
                    timer <= '0;
                    if (inside_button) begin
                        state <= BUTTON_HOLD;
                    end else if (entry.valid) begin
                        if (timeout_digit) begin
                            state <= TIMEOUT_BEEP; // Not counted as an attempt
                        end else begin
                            state <= CHECKING;
                            start <= 1'b1;
                        end
                    end
                end
                CHECKING: begin
                    if (result.done) begin
                        if (result.ok) begin
                            fail_count <= 3'd0;
                            state      <= UNLATCHED;
                        end else begin
                            fail_count <= fail_count + 3'd1;
                            if (fail_count == 3'(`LOCK_MAX_ATTEMPTS - 1)) begin
                                state <= LOCKOUT;
                            end else begin
                                state <= LOCKED;
                            end
                        end
                    end
                end
                UNLATCHED: begin
                    if (door_open) begin
                        state <= OPEN;
                        timer <= '0;
                    end else if (timer == TIMER_W'(`LOCK_RELOCK_CYCLES - 1)) begin
                        state <= LOCKED; // Relatch after the closed-door delay
                    end else begin
                        timer <= timer + 1'b1;
                    end
                end
                OPEN: begin
                    if (!door_open) begin
                        state <= UNLATCHED;
                        timer <= '0;
                    end else if (timer != TIMER_W'(`LOCK_BEEP_DELAY)) begin
                        timer <= timer + 1'b1; // Saturates at the beep delay
                    end
                end
                LOCKOUT: begin
                    if (timer == TIMER_W'(`LOCK_LOCKOUT_CYCLES - 1)) begin
                        state      <= LOCKED;
                        fail_count <= 3'd0;
                    end else begin
                        timer <= timer + 1'b1;
                    end
                end
                BUTTON_HOLD: begin
                    if (inside_button) begin
                        if (timer != TIMER_W'(`LOCK_DEBOUNCE_CYCLES)) timer <= timer + 1'b1;
                    end else if (timer == TIMER_W'(`LOCK_DEBOUNCE_CYCLES)) begin
                        state <= UNLATCHED; // Held long enough and released
                        timer <= '0;
                    end else begin
                        state <= LOCKED;    // Short press
                    end
                end
                TIMEOUT_BEEP: begin
                    state <= LOCKED;
                end
                default: begin
                    state <= INIT;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == LOCKED && entry.valid) begin
            entered <= entry.code;
        end
    end

    always_comb begin
        lock_out.latched   = 1'b1;
        lock_out.beep      = 1'b0;
        lock_out.keypad_en = (state == LOCKED);
        case (state)
            INIT, UNLATCHED: lock_out.latched = 1'b0;
            OPEN: begin
                lock_out.latched = 1'b0;
                lock_out.beep    = (timer == TIMER_W'(`LOCK_BEEP_DELAY));
            end
            TIMEOUT_BEEP: lock_out.beep = 1'b1;
            default: ;
        endcase
    end

    assign lockout = (state == LOCKOUT);

    // Lockout follows the last allowed failure and keeps the door latched
    a_lockout_latched: assert property (
        @(posedge clk) disable iff (rst)
        (state == LOCKOUT) |-> lock_out.latched && fail_count == 3'(`LOCK_MAX_ATTEMPTS)
    );

endmodule

// ==== door_lock_top.sv ====
`timescale 1ns/100ps

module door_lock_top
    import keypad_pkg::*;
    import door_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  key_entry_t  entry,
    input  logic        door_open,
    input  logic        inside_button,
    input  code_slots_t user_codes,
    output lock_out_t   lock_out,
    output display_t    display
);

    logic          start;
    code_t         entered;
    match_result_t result;
    lock_out_t     fsm_lock_out; // Unregistered outputs from the FSM
    logic [2:0]    fail_count;
    logic          lockout;

    code_matcher u_matcher (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .entered    (entered),
        .user_codes (user_codes),
        .result     (result)
    );

    door_fsm u_fsm (
        .clk           (clk),
        .rst           (rst),
        .entry         (entry),
        .door_open     (door_open),
        .inside_button (inside_button),
        .result        (result),
        .start         (start),
        .entered       (entered),
        .lock_out      (fsm_lock_out),
        .fail_count    (fail_count),
        .lockout       (lockout)
    );

    lock_display u_display (
        .clk         (clk),
        .rst         (rst),
        .lock_out_in (fsm_lock_out),
        .fail_count  (fail_count),
        .lockout     (lockout),
        .lock_out    (lock_out),
        .display     (display)
    );

endmodule

// ==== door_pkg.sv ====
package door_pkg;

    // Door controller states
    typedef enum logic [2:0] {
        INIT,         // Waits for the door to close after reset
        LOCKED,       // Door latched, keypad accepting entries
        CHECKING,     // Code comparison in progress
        UNLATCHED,    // Door closed but free, relock timer running
        OPEN,         // Door open
        LOCKOUT,      // Too many failures, keypad ignored
        BUTTON_HOLD,  // Inside button pressed, debounce running
        TIMEOUT_BEEP  // Keypad timed out, single beep
    } door_state_t;

    // Matcher answer, ok only valid together with done
    typedef struct packed {
        logic done;
        logic ok;
    } match_result_t;

    // Lock outputs
    typedef struct packed {
        logic latched;
        logic beep;
        logic keypad_en;
    } lock_out_t;

endpackage

// ==== keypad_pkg.sv ====
package keypad_pkg;

    // One BCD digit as delivered by the keypad
    typedef logic [3:0] digit_t;

    // Four-digit code, digit 3 is the first key pressed
    typedef digit_t [3:0] code_t;

    // Stored user codes, slot 0 in the low bits
    typedef struct packed {
        code_t slot3;
        code_t slot2;
        code_t slot1;
        code_t slot0;
    } code_slots_t;

    // Completed keypad entry, code is only meaningful while valid
    typedef struct packed {
        logic  valid;
        code_t code;
    } key_entry_t;

    // Six display digits, d0 is the leftmost one
    typedef struct packed {
        digit_t d5;
        digit_t d4;
        digit_t d3;
        digit_t d2;
        digit_t d1;
        digit_t d0;
    } display_t;

endpackage

// ==== lock_defs.svh ====
`ifndef LOCK_DEFS_SVH
`define LOCK_DEFS_SVH

// Timing values in clock cycles, scaled down for simulation

// Closed, unlatched door relatches after this
`define LOCK_RELOCK_CYCLES   40

// Open door starts to beep after this
`define LOCK_BEEP_DELAY      30

// Keypad lockout length, the longest interval of the lock
`define LOCK_LOCKOUT_CYCLES  60

// Minimum hold time of the inside button
`define LOCK_DEBOUNCE_CYCLES 8

// Failed attempts that trigger the lockout
`define LOCK_MAX_ATTEMPTS    5

// Special digit values
`define LOCK_DIGIT_TIMEOUT   4'hE // Sent by the keypad on entry timeout
`define LOCK_DIGIT_BLANK     4'hB // Dark display digit, also marks an unused slot
`define LOCK_DIGIT_ERR       4'hA // One mark per failed attempt

`endif

// ==== lock_display.sv ====
`timescale 1ns/100ps

`include "lock_defs.svh"

module lock_display
    import keypad_pkg::*;
    import door_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  lock_out_t  lock_out_in,
    input  logic [2:0] fail_count,
    input  logic       lockout,
    output lock_out_t  lock_out,
    output display_t   display
);

    digit_t [5:0] digits; // Index 0 maps to d0

    // One error mark per failed attempt, all six during lockout
    always_comb begin
        for (int i = 0; i < 6; i++) begin
            if (lockout || (i < int'(fail_count))) begin
                digits[i] = `LOCK_DIGIT_ERR;
            end else begin
                digits[i] = `LOCK_DIGIT_BLANK;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lock_out <= '0;
            display  <= display_t'({6{`LOCK_DIGIT_BLANK}});
        end else begin
            lock_out <= lock_out_in;
            display  <= display_t'(digits);
        end
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the door lock testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f sim.f --top-module tb_door_lock
./obj_dir/Vtb_door_lock

// ==== sim.f ====
+incdir+.
keypad_pkg.sv
door_pkg.sv
code_matcher.sv
door_fsm.sv
lock_display.sv
door_lock_top.sv
tb_door_lock.sv

// ==== tb_door_lock.sv ====
`timescale 1ns/100ps

`include "lock_defs.svh"

module tb_door_lock
    import keypad_pkg::*;
    import door_pkg::*;
();

    localparam int CLK_PERIOD = 10;
    // Rough length of all tests in cycles
    localparam int RUN_CYCLES = 100 + 4 * (`LOCK_RELOCK_CYCLES + 30) + `LOCK_LOCKOUT_CYCLES
                              + 6 * 30 + `LOCK_BEEP_DELAY + 3 * `LOCK_DEBOUNCE_CYCLES;

    logic        clk;
    logic        rst;
    key_entry_t  entry;
    logic        door_open;
    logic        inside_button;
    code_slots_t user_codes;
    lock_out_t   lock_out;
    display_t    display;

    code_t       slot_list [4];
    logic [31:0] rng_state;
    int          fail_total; // Failed attempts the model expects on the display

    door_lock_top UUT (
        .clk           (clk),
        .rst           (rst),
        .entry         (entry),
        .door_open     (door_open),
        .inside_button (inside_button),
        .user_codes    (user_codes),
        .lock_out      (lock_out),
        .display       (display)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Twice the expected run length
    initial begin
        #(2 * RUN_CYCLES * CLK_PERIOD);
        $display("Watchdog expired, the tests did not finish in time");
        $display("TEST FAIL");
        $fatal(1, "Simulation timed out");
    end

    function automatic logic [31:0] xorshift();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // Reference match rule where a blank slot never matches
    function automatic bit matches_slot(input code_t c);
        bit hit;
        hit = 1'b0;
        for (int i = 0; i < 4; i++) begin
            if (slot_list[i] != {4{`LOCK_DIGIT_BLANK}} && slot_list[i] == c) hit = 1'b1;
        end
        return hit;
    endfunction

    function automatic code_t wrong_code();
        code_t c;
        do begin
            for (int i = 0; i < 4; i++)
                c[i] = digit_t'(xorshift() % 10); // BCD digits only
        end while (matches_slot(c));
        return c;
    endfunction

    function automatic display_t expected_display(input int fails, input bit locked_out);
        logic [23:0] v;
        v = {6{`LOCK_DIGIT_BLANK}};
        for (int i = 0; i < 6; i++) begin
            if (locked_out || i < fails) v[i*4 +: 4] = `LOCK_DIGIT_ERR;
        end
        return display_t'(v);
    endfunction

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        assert (got === exp) else begin
            $display("ERR t=%0t %s got %0h expected %0h", $time, name, got, exp);
            $display("TEST FAIL");
            $fatal(1, "Value mismatch");
        end
    endtask

    task automatic require(input bit cond, input string what);
        assert (cond) else begin
            $display("Check failed at %0t: %s", $time, what);
            $display("TEST FAIL");
            $fatal(1, "Check failed");
        end
    endtask

    // One-cycle entry pulse
    task automatic send_entry(input code_t c);
        @(negedge clk);
        entry.valid = 1'b1;
        entry.code  = c;
        @(negedge clk);
        entry.valid = 1'b0;
        entry.code  = '0;
    endtask

    // Door must stay latched while the keypad is busy
    task automatic wait_keypad_ready(input int max_cycles);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            compare_value("latched", 32'(lock_out.latched), 32'd1);
            n++;
        end while (lock_out.keypad_en !== 1'b1 && n < max_cycles);
        require(lock_out.keypad_en === 1'b1, "keypad was not enabled in time");
    endtask

    task automatic unlatch_by_code(input code_t c);
        int n;
        wait_keypad_ready(10);
        send_entry(c);
        n = 0;
        while (lock_out.latched !== 1'b0 && n < 8) begin
            @(negedge clk);
            n++;
        end
        require(lock_out.latched === 1'b0, "correct code did not unlatch the door");
    endtask

    task automatic wait_relatch();
        int n;
        n = 0;
        while (lock_out.latched !== 1'b1 && n < `LOCK_RELOCK_CYCLES + 10) begin
            @(negedge clk);
            n++;
        end
        require(lock_out.latched === 1'b1, "door did not relatch after the relock time");
        require(n >= `LOCK_RELOCK_CYCLES - 2, "door relatched before the relock time");
    endtask

    task automatic reset_and_close();
        int n;
        repeat (5) @(negedge clk);
        compare_value("lock_out", 32'(lock_out), 32'd0);
        compare_value("display", 32'(display), 32'(expected_display(0, 1'b0)));
        rst = 1'b0;
        repeat (3) @(negedge clk);
        compare_value("latched", 32'(lock_out.latched), 32'd0); // Still in INIT
        door_open = 1'b0;
        n = 0;
        while (lock_out.latched !== 1'b1 && n < 5) begin
            @(negedge clk);
            n++;
        end
        require(lock_out.latched === 1'b1, "door did not latch after closing");
    endtask

    task automatic correct_code();
        int idx;
        idx = int'(xorshift() % 4);
        unlatch_by_code(slot_list[idx]);
        wait_relatch();
    endtask

    task automatic wrong_codes_lockout();
        int n;
        for (int k = 1; k <= `LOCK_MAX_ATTEMPTS; k++) begin
            wait_keypad_ready(10);
            send_entry(wrong_code());
            fail_total++;
            if (k < `LOCK_MAX_ATTEMPTS) begin
                wait_keypad_ready(10);
                compare_value("display", 32'(display),
                              32'(expected_display(fail_total, 1'b0)));
            end
        end
        n = 0;
        while (display !== expected_display(0, 1'b1) && n < 10) begin
            @(negedge clk);
            compare_value("latched", 32'(lock_out.latched), 32'd1);
            n++;
        end
        require(display === expected_display(0, 1'b1), "lockout did not show six error marks");
        compare_value("keypad_en", 32'(lock_out.keypad_en), 32'd0);
        send_entry(slot_list[0]); // Must be ignored
        // Marks and latch hold for nearly the whole lockout
        repeat (`LOCK_LOCKOUT_CYCLES - 4) begin
            @(negedge clk);
            compare_value("latched", 32'(lock_out.latched), 32'd1);
            compare_value("display", 32'(display), 32'(expected_display(0, 1'b1)));
        end
        fail_total = 0;
        wait_keypad_ready(10);
        compare_value("display", 32'(display), 32'(expected_display(0, 1'b0)));
        unlatch_by_code(slot_list[int'(xorshift() % 4)]);
        wait_relatch();
    endtask

    task automatic open_door_beep();
        int n;
        unlatch_by_code(slot_list[int'(xorshift() % 4)]);
        @(negedge clk);
        door_open = 1'b1;
        n = 0;
        while (lock_out.beep !== 1'b1 && n < `LOCK_BEEP_DELAY + 5) begin
            @(negedge clk);
            n++;
        end
        require(lock_out.beep === 1'b1, "open door did not beep");
        require(n >= `LOCK_BEEP_DELAY, "open door beeped before the beep delay");
        repeat (3) begin
            @(negedge clk);
            compare_value("beep", 32'(lock_out.beep), 32'd1);
        end
        door_open = 1'b0;
        repeat (2) @(negedge clk);
        compare_value("beep", 32'(lock_out.beep), 32'd0);
        compare_value("latched", 32'(lock_out.latched), 32'd0);
        wait_relatch();
    endtask

    task automatic inside_button_press();
        int n;
        wait_keypad_ready(10);
        inside_button = 1'b1;
        repeat (`LOCK_DEBOUNCE_CYCLES + 3) begin
            @(negedge clk);
            compare_value("latched", 32'(lock_out.latched), 32'd1);
        end
        inside_button = 1'b0; // Unlatch happens on release
        n = 0;
        while (lock_out.latched !== 1'b0 && n < 5) begin
            @(negedge clk);
            n++;
        end
        require(lock_out.latched === 1'b0, "released button did not unlatch the door");
        wait_relatch();

        // Short press
        wait_keypad_ready(10);
        inside_button = 1'b1;
        repeat (3) @(negedge clk);
        inside_button = 1'b0;
        repeat (`LOCK_DEBOUNCE_CYCLES + 4) begin
            @(negedge clk);
            compare_value("latched", 32'(lock_out.latched), 32'd1);
        end
        wait_keypad_ready(10);
    endtask

    task automatic timeout_digit_beep();
        code_t c;
        int    n;
        wait_keypad_ready(10);
        c    = wrong_code();
        c[3] = `LOCK_DIGIT_TIMEOUT;
        send_entry(c);
        n = 0;
        while (lock_out.beep !== 1'b1 && n < 4) begin
            @(negedge clk);
            compare_value("latched", 32'(lock_out.latched), 32'd1);
            n++;
        end
        require(lock_out.beep === 1'b1, "timeout digit gave no beep");
        @(negedge clk);
        compare_value("beep", 32'(lock_out.beep), 32'd0); // Single-cycle beep
        wait_keypad_ready(10);
        compare_value("display", 32'(display), 32'(expected_display(fail_total, 1'b0)));
    endtask

    initial begin
        rng_state     = 32'd7;
        fail_total    = 0;
        rst           = 1'b1;
        entry         = '0;
        door_open     = 1'b1; // Open during reset so INIT is visible
        inside_button = 1'b0;
        slot_list[0]  = 16'h1234;
        slot_list[1]  = 16'h5678;
        slot_list[2]  = 16'h9021;
        slot_list[3]  = 16'h4680;
        user_codes    = {slot_list[3], slot_list[2], slot_list[1], slot_list[0]};

        reset_and_close();
        correct_code();
        wrong_codes_lockout();
        open_door_beep();
        inside_button_press();
        timeout_digit_beep();

        $display("TEST PASS");
        $finish;
    end

endmodule
